// ==== tb/mdecTests.txt ====
# name op reg data expected, all numbers hex
# table reg: 0 quant chroma, 1 quant luma, 2 cosine; ready expected is halves seen
idleStat read 1 0 0000FFFF
dmaOn write 1 40000000 0
quantCmd write 0 40000001 0
quantStat read 1 0 3000001F
quant0 table 1 81828384 00208184
quant1 table 1 05060708 10A18388
quantLeft read 1 0 3000001D
softRst write 1 80000000 0
rstStat read 1 0 0000FFFF
cosCmd write 0 60000000 0
cos0 table 2 12345678 0048CACF
cos1 table 2 FFFFFFFF 07FFFFFF
softRst2 write 1 80000000 0
dmaOn2 write 1 40000000 0
strCmd write 0 2E000003 0
strStat read 1 0 33800002
strW0 write 0 BBBBAAAA 0
strW1 write 0 DDDDCCCC 0
fullStat read 1 0 63800002
readyOn ready 0 1 0
half0 stream 0 0 0000AAAA
half1 stream 0 0 0000BBBB
half2 stream 0 0 0000CCCC
half3 stream 0 0 0000DDDD
strW2 write 0 1111EEEE 0
half4 stream 0 0 0000EEEE
half5 stream 0 0 00001111
doneStat read 1 0 0380FFFF

// ==== mdecFrontEnd.f ====
src/mdecRegPkg.sv
src/mdecTablePkg.sv
src/mdecCmdFsm.sv
src/mdecParamCounter.sv
src/mdecInFifo.sv
src/mdecTableLoader.sv
src/mdecRegBank.sv
src/mdecFrontEnd.sv
tb/mdecFrontEndTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f mdecFrontEnd.f --top-module mdecFrontEndTb -o simTb
./obj_dir/simTb > sim.log 2>&1 || true
cat sim.log
grep -q "Simulation passed" sim.log

// ==== tb/mdecFrontEndTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mdecFrontEndTb;
	import mdecRegPkg::*;
	import mdecTablePkg::*;

	logic       i_clk;
	logic       i_resetChip;
	logic       i_cs;
	logic       i_regSelect;
	logic       i_write;
	logic       i_read;
	regWordT    i_valueIn;
	logic       i_dma0Ack;
	logic       i_streamReady;
	regWordT    o_valueOut;
	logic       o_dma0Req;
	logic       o_streamValid;
	halfWordT   o_streamData;
	logic       o_cosWrite;
	cosIndexT   o_cosIndex;
	cosValueT   o_cosValue;
	logic       o_quantWrite;
	quantAdrT   o_quantAdr;
	quantValueT o_quantValue;
	logic       o_quantLuma;

	string         names [$];
	string         ops   [$];
	logic [31:0]   regs  [$];
	logic [31:0]   datas [$];
	logic [31:0]   exps  [$];
	logic [15:0]   halves [$];	// Stream halves seen in arrival order
	int            numTests = 0;
	int            errors = 0;

	// Depth of two so back-pressure fills the FIFO quickly
	mdecFrontEnd #(.FIFO_DEPTH_LOG2(1)) UUT (
		.i_clk(i_clk), .i_resetChip(i_resetChip), .i_cs(i_cs), .i_regSelect(i_regSelect),
		.i_write(i_write), .i_read(i_read), .i_valueIn(i_valueIn), .i_dma0Ack(i_dma0Ack),
		.i_streamReady(i_streamReady), .o_valueOut(o_valueOut), .o_dma0Req(o_dma0Req),
		.o_streamValid(o_streamValid), .o_streamData(o_streamData),
		.o_cosWrite(o_cosWrite), .o_cosIndex(o_cosIndex), .o_cosValue(o_cosValue),
		.o_quantWrite(o_quantWrite), .o_quantAdr(o_quantAdr), .o_quantValue(o_quantValue),
		.o_quantLuma(o_quantLuma)
	);

	always #50 i_clk = ~i_clk;	// 100 ns period

	// Collect every half the DUT emits
	always @(negedge i_clk) begin
		if (!i_resetChip && o_streamValid) halves.push_back(o_streamData);
	end

	task automatic checkValue(input string testName, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("mismatch %s expected %h actual %h", testName, expected, actual);
			errors++;
		end
	endtask

	task automatic loadTests(input int fd);
		string       line;
		string       nameTmp;
		string       opTmp;
		logic [31:0] r;
		logic [31:0] d;
		logic [31:0] e;
		int          code;
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			if (code > 0 && line.len() > 1 && line.substr(0, 0) != "#") begin	// Skip comments
				code = $sscanf(line, "%s %s %h %h %h", nameTmp, opTmp, r, d, e);
				if (code == 5) begin
					names.push_back(nameTmp);
					ops.push_back(opTmp);
					regs.push_back(r);
					datas.push_back(d);
					exps.push_back(e);
				end
			end
		end
	endtask

	// Bus cycle of one clock that busIdle ends on the following edge
	task automatic busAccess(input logic isWrite, input logic sel, input logic [31:0] data);
		@(posedge i_clk);
		i_cs        <= 1'b1;
		i_write     <= isWrite;
		i_read      <= !isWrite;
		i_regSelect <= sel;
		i_valueIn   <= data;
	endtask

	task automatic busIdle();
		@(posedge i_clk);
		i_cs    <= 1'b0;
		i_write <= 1'b0;
		i_read  <= 1'b0;
	endtask

	task automatic runStep(input int idx);
		logic [31:0] captured;
		int          waitCount;
		case (ops[idx])
			"write": begin
				busAccess(1'b1, regs[idx][0], datas[idx]);
				busIdle();
			end
			"read": begin
				busAccess(1'b0, regs[idx][0], '0);
				busIdle();						// Select is registered on this edge
				@(negedge i_clk);
				checkValue(names[idx], exps[idx], o_valueOut);
				// Request pin follows the status request bit
				checkValue(names[idx], {31'd0, exps[idx][STAT_DMA0_BIT]}, {31'd0, o_dma0Req});
			end
			"table": begin
				busAccess(1'b1, 1'b0, datas[idx]);
				@(negedge i_clk);				// Table strobes are combinational
				if (regs[idx] == 2) begin
					checkValue(names[idx], 32'd1, {31'd0, o_cosWrite});
					checkValue(names[idx], exps[idx], {1'b0, o_cosIndex, o_cosValue});
				end else begin
					checkValue(names[idx], 32'd1, {31'd0, o_quantWrite});
					checkValue(names[idx], regs[idx], {31'd0, o_quantLuma});
					checkValue(names[idx], exps[idx], {o_quantAdr, o_quantValue});
				end
				busIdle();
			end
			"ready": begin
				@(posedge i_clk);
				checkValue(names[idx], exps[idx], halves.size());	// Halves seen so far
				i_streamReady <= datas[idx][0];
			end
			"stream": begin
				waitCount = 0;
				while (halves.size() == 0 && waitCount < 40) begin
					@(posedge i_clk);
					waitCount++;
				end
				if (halves.size() == 0) begin
					$display("%s: no stream half arrived in time", names[idx]);
					errors++;
				end else begin
					captured = {16'd0, halves.pop_front()};
					checkValue(names[idx], exps[idx], captured);
				end
			end
			default: begin
				$display("%s: unknown operation %s", names[idx], ops[idx]);
				errors++;
			end
		endcase
	endtask

	// ------------------------------------------------
	// Main sequence
	// ------------------------------------------------
	initial begin
		int fd;
		i_clk         = 1'b0;
		i_resetChip   = 1'b1;
		i_cs          = 1'b0;
		i_regSelect   = 1'b0;
		i_write       = 1'b0;
		i_read        = 1'b0;
		i_valueIn     = '0;
		i_dma0Ack     = 1'b0;
		i_streamReady = 1'b0;
		fd = $fopen("tb/mdecTests.txt", "r");
		if (fd == 0) begin
			$display("could not open the tests file tb/mdecTests.txt");
			$display("Simulation failed");
			$finish;
		end else begin
			loadTests(fd);
			$fclose(fd);
			numTests = names.size();
			if (numTests == 0) begin
				$display("no test lines were found in tb/mdecTests.txt");
				errors++;
			end
			repeat (5) @(posedge i_clk);
			i_resetChip <= 1'b0;
			for (int i = 0; i < numTests; i++) runStep(i);
			repeat (3) @(posedge i_clk);
			$display("tests: %0d errors: %0d", numTests, errors);
			if (errors == 0) begin
				$display("Simulation passed");
			end else begin
				$display("Simulation failed");
			end
			$finish;
		end
	end

	// Watchdog allows 20 cycles per test line plus reset
	initial begin
		wait (numTests > 0);
		#((numTests + 5) * 20 * 100);
		$display("timeout: the tests did not finish in the allowed time");
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/mdecFrontEnd.sv ====
`timescale 1ns/1ps
`default_nettype none

module mdecFrontEnd #(
	parameter int FIFO_DEPTH_LOG2 = 4
) (
	input  wire                      i_clk,
	input  wire                      i_resetChip,
	input  wire                      i_cs,
	input  wire                      i_regSelect,	// 0 data port, 1 control/status
	input  wire                      i_write,
	input  wire                      i_read,
	input  wire mdecRegPkg::regWordT i_valueIn,
	input  wire                      i_dma0Ack,
	input  wire                      i_streamReady,
	output mdecRegPkg::regWordT      o_valueOut,
	output logic                     o_dma0Req,
	output logic                     o_streamValid,
	output mdecTablePkg::halfWordT   o_streamData,
	output logic                     o_cosWrite,
	output mdecTablePkg::cosIndexT   o_cosIndex,
	output mdecTablePkg::cosValueT   o_cosValue,
	output logic                     o_quantWrite,
	output mdecTablePkg::quantAdrT   o_quantAdr,
	output mdecTablePkg::quantValueT o_quantValue,
	output logic                     o_quantLuma
);
	import mdecRegPkg::*;

	logic        reg0Write;
	logic        reg1Write;
	logic        readReg1;
	logic        softReset;
	logic        resetChip;
	cmdCodeT     cmdCode;
	logic        cntLoad;
	logic        decOne;
	logic        decTwo;
	logic        popLo;
	logic        popHi;
	logic        cosWr;
	logic        quantWr;
	logic        lumaSel;
	logic        streamStart;
	logic        idle;
	logic        lastHalf;
	logic        groupDone;
	logic [15:0] wordsLeftM1;
	logic        fifoHasData;
	logic        fifoFull;
	logic        streamPush;

	// ------------------------------------------------
	// Bus strobes
	// ------------------------------------------------
	assign reg0Write = (i_cs && i_write && !i_regSelect) || i_dma0Ack;
	assign reg1Write = i_cs && i_write && i_regSelect;
	assign readReg1  = i_cs && i_read && i_regSelect;
	assign resetChip = i_resetChip || softReset;
	assign cmdCode   = i_valueIn[31:29];

	// Busy and not a table state means stream
	assign streamPush = reg0Write && !idle && !cosWr && !quantWr;

	mdecCmdFsm cmdFsm (
		.i_clk(i_clk), .i_resetChip(resetChip), .i_reg0Write(reg0Write),
		.i_cmdCode(cmdCode), .i_chromaFlag(i_valueIn[0]), .i_fifoHasData(fifoHasData),
		.i_streamReady(i_streamReady), .i_lastHalf(lastHalf), .i_groupDone(groupDone),
		.o_cntLoad(cntLoad), .o_decOne(decOne), .o_decTwo(decTwo),
		.o_popLo(popLo), .o_popHi(popHi), .o_cosWrite(cosWr), .o_quantWrite(quantWr),
		.o_lumaSel(lumaSel), .o_streamStart(streamStart), .o_idle(idle)
	);

	mdecParamCounter paramCounter (
		.i_clk(i_clk), .i_resetChip(resetChip), .i_load(cntLoad), .i_cmdWord(i_valueIn),
		.i_decOne(decOne), .i_decTwo(decTwo), .o_lastHalf(lastHalf),
		.o_groupDone(groupDone), .o_wordsLeftM1(wordsLeftM1)
	);

	mdecInFifo #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) inFifo (
		.i_clk(i_clk), .i_resetChip(resetChip), .i_flush(streamStart), .i_push(streamPush),
		.i_wordIn(i_valueIn), .i_popLo(popLo), .i_popHi(popHi), .o_hasData(fifoHasData),
		.o_full(fifoFull), .o_streamValid(o_streamValid), .o_streamData(o_streamData)
	);

	// Next count rebuilt from the status field, always even during table loads
	mdecTableLoader tableLoader (
		.i_cosWrite(cosWr), .i_quantWrite(quantWr), .i_lumaSel(lumaSel),
		.i_wordIn(i_valueIn), .i_halfCount({wordsLeftM1, 1'b0}),
		.o_cosWrite(o_cosWrite), .o_cosIndex(o_cosIndex), .o_cosValue(o_cosValue),
		.o_quantWrite(o_quantWrite), .o_quantAdr(o_quantAdr), .o_quantValue(o_quantValue),
		.o_quantLuma(o_quantLuma)
	);

	mdecRegBank regBank (
		.i_clk(i_clk), .i_resetChip(resetChip), .i_reg0Write(reg0Write),
		.i_reg1Write(reg1Write), .i_cmdWord(i_valueIn), .i_idle(idle),
		.i_fifoFull(fifoFull), .i_dma0Ack(i_dma0Ack), .i_wordsLeftM1(wordsLeftM1),
		.i_regSelect(readReg1), .o_softReset(softReset), .o_dma0Req(o_dma0Req),
		.o_valueOut(o_valueOut)
	);

endmodule

`default_nettype wire

// ==== src/mdecRegBank.sv ====
`timescale 1ns/1ps
`default_nettype none

module mdecRegBank (
	input  wire                      i_clk,
	input  wire                      i_resetChip,
	input  wire                      i_reg0Write,
	input  wire                      i_reg1Write,
	input  wire mdecRegPkg::regWordT i_cmdWord,		// Bus data in
	input  wire                      i_idle,
	input  wire                      i_fifoFull,
	input  wire                      i_dma0Ack,
	input  wire [15:0]               i_wordsLeftM1,
	input  wire                      i_regSelect,	// Status read strobe
	output logic                     o_softReset,
	output logic                     o_dma0Req,
	output mdecRegPkg::regWordT      o_valueOut
);
	import mdecRegPkg::*;

	pixFormatT pixFormat;
	logic      pixSigned;
	logic      pixSetMask;	// Bit 15 forced in 15-bit mode
	logic      dma0Enable;
	logic      pRegSelect;
	regWordT   statusWord;

	assign o_softReset = i_reg1Write && i_cmdWord[CTRL_RESET_BIT];

	// No request while idle, full, or a word is being taken
	assign o_dma0Req = !i_idle && dma0Enable && !i_fifoFull && !i_dma0Ack;

	always_ff @(posedge i_clk) begin
		if (i_resetChip) begin
			pixFormat  <= '0;
			pixSigned  <= 1'b0;
			pixSetMask <= 1'b0;
			dma0Enable <= 1'b0;
			pRegSelect <= 1'b0;
		end else begin
			pRegSelect <= i_regSelect;
			if (i_reg0Write && i_idle) begin	// Any new command, even unknown
				pixFormat  <= i_cmdWord[28:27];
				pixSigned  <= i_cmdWord[26];
				pixSetMask <= i_cmdWord[25];
			end
			if (i_reg1Write) dma0Enable <= i_cmdWord[CTRL_DMA0_BIT];
		end
	end

	// ------------------------------------------------
	// Status word
	// ------------------------------------------------
	always_comb begin
		statusWord                = '0;		// Output side bits stay zero
		statusWord[STAT_FULL_BIT] = i_fifoFull;
		statusWord[STAT_BUSY_BIT] = !i_idle;
		statusWord[STAT_DMA0_BIT] = o_dma0Req;
		statusWord[26:25]         = pixFormat;
		statusWord[24]            = pixSigned;
		statusWord[23]            = pixSetMask;
		statusWord[15:0]          = i_wordsLeftM1;
	end

	assign o_valueOut = pRegSelect ? statusWord : '0;	// Data port reads zero

endmodule

`default_nettype wire

// ==== src/mdecTableLoader.sv ====
`timescale 1ns/1ps
`default_nettype none

module mdecTableLoader (
	input  wire                          i_cosWrite,
	input  wire                          i_quantWrite,
	input  wire                          i_lumaSel,
	input  wire mdecRegPkg::regWordT     i_wordIn,
	input  wire mdecTablePkg::halfCountT i_halfCount,	// Count after this write
	output logic                         o_cosWrite,
	output mdecTablePkg::cosIndexT       o_cosIndex,
	output mdecTablePkg::cosValueT       o_cosValue,
	output logic                         o_quantWrite,
	output mdecTablePkg::quantAdrT       o_quantAdr,
	output mdecTablePkg::quantValueT     o_quantValue,
	output logic                         o_quantLuma
);

	// ------------------------------------------------
	// Cosine table
	// ------------------------------------------------
	assign o_cosWrite = i_cosWrite;
	assign o_cosIndex = ~i_halfCount[5:1];		// Count 31..0 gives index 0..31

	// Two signed 13-bit values, low 3 bits of each half dropped
	assign o_cosValue = {i_wordIn[31:19], i_wordIn[15:3]};

	// ------------------------------------------------
	// Quantization table
	// ------------------------------------------------
	assign o_quantWrite = i_quantWrite;
	assign o_quantAdr   = ~i_halfCount[4:1];	// Wraps to 0 for the chroma group
	assign o_quantLuma  = i_lumaSel;			// 1 luma, 0 chroma

	// Top bit of each byte is ignored
	assign o_quantValue = {
		i_wordIn[30:24],
		i_wordIn[22:16],
		i_wordIn[14:8],
		i_wordIn[6:0]
	};

endmodule

`default_nettype wire

// ==== src/mdecInFifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module mdecInFifo #(
	parameter int FIFO_DEPTH_LOG2 = 4
) (
	input  wire                      i_clk,
	input  wire                      i_resetChip,
	input  wire                      i_flush,		// New stream command
	input  wire                      i_push,
	input  wire mdecRegPkg::regWordT i_wordIn,
	input  wire                      i_popLo,
	input  wire                      i_popHi,
	output logic                     o_hasData,
	output logic                     o_full,
	output logic                     o_streamValid,
	output mdecTablePkg::halfWordT   o_streamData
);
	import mdecRegPkg::*;
	import mdecTablePkg::*;

	localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

	regWordT                  mem [0:DEPTH-1];
	logic [FIFO_DEPTH_LOG2:0] wrPtr;		// Extra bit tells full from empty
	logic [FIFO_DEPTH_LOG2:0] rdPtr;
	regWordT                  headWord;
	logic                     pushOk;
	halfWordT                 popHalf;

	assign o_hasData = (wrPtr != rdPtr);
	assign o_full    = (wrPtr[FIFO_DEPTH_LOG2] != rdPtr[FIFO_DEPTH_LOG2])
	                   && (wrPtr[FIFO_DEPTH_LOG2-1:0] == rdPtr[FIFO_DEPTH_LOG2-1:0]);
	assign pushOk    = i_push && !o_full;	// Dropped when full
	assign headWord  = mem[rdPtr[FIFO_DEPTH_LOG2-1:0]];
	assign popHalf   = i_popLo ? headWord[15:0] : headWord[31:16];

	always_ff @(posedge i_clk) begin
		if (pushOk) mem[wrPtr[FIFO_DEPTH_LOG2-1:0]] <= i_wordIn;
		if (i_popLo || i_popHi) o_streamData <= popHalf;
	end

	always_ff @(posedge i_clk) begin
		if (i_resetChip || i_flush) begin
			wrPtr         <= '0;
			rdPtr         <= '0;
			o_streamValid <= 1'b0;
		end else begin
			o_streamValid <= i_popLo || i_popHi;
			if (pushOk) wrPtr <= wrPtr + 1'b1;
			if (i_popHi && o_hasData) rdPtr <= rdPtr + 1'b1;	// Word retired after high half
		end
	end

	assert property (@(posedge i_clk) disable iff (i_resetChip) !(i_push && o_full))
		else $error("stream word written to full FIFO");

endmodule

`default_nettype wire

// ==== src/mdecParamCounter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mdecParamCounter (
	input  wire                      i_clk,
	input  wire                      i_resetChip,
	input  wire                      i_load,
	input  wire mdecRegPkg::regWordT i_cmdWord,
	input  wire                      i_decOne,	// Stream pop
	input  wire                      i_decTwo,	// Table word write
	output logic                     o_lastHalf,
	output logic                     o_groupDone,
	output logic [15:0]              o_wordsLeftM1
);
	import mdecRegPkg::*;
	import mdecTablePkg::*;

	halfCountT halfCount;
	halfCountT nextCount;
	cmdCodeT   loadCmd;

	assign loadCmd = i_cmdWord[31:29];

	// Minus one or two, also seen when holding
	assign nextCount = halfCount - (i_decTwo ? halfCountT'(2) : halfCountT'(1));

	assign o_lastHalf    = (nextCount == '0);
	assign o_groupDone   = (nextCount[4:1] == 4'd0);	// Every 16 words of quant
	assign o_wordsLeftM1 = nextCount[16:1];				// FFFF once the count is zero

	always_ff @(posedge i_clk) begin
		if (i_resetChip) begin
			halfCount <= '0;
		end else if (i_load) begin
			case (loadCmd)
				CMD_QUANT: begin
					// Luma only or luma plus chroma
					halfCount <= i_cmdWord[0] ? halfCountT'(QUANT_WORDS * 4)
					                          : halfCountT'(QUANT_WORDS * 2);
				end
				CMD_COSTBL: halfCount <= halfCountT'(COS_WORDS * 2);
				default:    halfCount <= {i_cmdWord[15:0], 1'b0};	// Stream words to halves
			endcase
		end else if (i_decOne || i_decTwo) begin
			halfCount <= nextCount;
		end
	end

	assert property (@(posedge i_clk) disable iff (i_resetChip) !(i_decOne && i_decTwo))
		else $error("stream pop and table write in the same cycle");

endmodule

`default_nettype wire

// ==== src/mdecCmdFsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module mdecCmdFsm (
	input  wire                 i_clk,
	input  wire                 i_resetChip,
	input  wire                 i_reg0Write,
	input  wire mdecRegPkg::cmdCodeT i_cmdCode,
	input  wire                 i_chromaFlag,	// Bit 0 of the quant command
	input  wire                 i_fifoHasData,
	input  wire                 i_streamReady,
	input  wire                 i_lastHalf,
	input  wire                 i_groupDone,
	output logic                o_cntLoad,
	output logic                o_decOne,
	output logic                o_decTwo,
	output logic                o_popLo,
	output logic                o_popHi,
	output logic                o_cosWrite,
	output logic                o_quantWrite,
	output logic                o_lumaSel,
	output logic                o_streamStart,
	output logic                o_idle
);
	import mdecRegPkg::*;

	cmdStateT state;
	cmdStateT nextState;
	logic     chromaReg;		// Quant command also loads chroma
	logic     knownCmd;
	logic     canPop;

	assign o_idle     = (state == WAIT_COMMAND);
	assign knownCmd   = (i_cmdCode == CMD_STREAM) || (i_cmdCode == CMD_QUANT)
	                    || (i_cmdCode == CMD_COSTBL);
	assign o_cntLoad  = o_idle && i_reg0Write && knownCmd;
	assign canPop     = i_fifoHasData && i_streamReady;	// Downstream holds when not ready

	// Table writes follow the bus strobe in the same cycle
	assign o_cosWrite   = i_reg0Write && (state == LOAD_COS);
	assign o_quantWrite = i_reg0Write && ((state == LOAD_LUMA) || (state == LOAD_CHROMA));
	assign o_lumaSel    = (state == LOAD_LUMA);
	assign o_decTwo     = o_cosWrite || o_quantWrite;	// One full word per table write

	assign o_popLo       = (state == LOAD_STREAM_LO) && canPop;
	assign o_popHi       = (state == LOAD_STREAM_HI) && canPop;
	assign o_decOne      = o_popLo || o_popHi;
	assign o_streamStart = o_cntLoad && (i_cmdCode == CMD_STREAM);	// Flushes the FIFO

	// ------------------------------------------------
	// Next state
	// ------------------------------------------------
	always_comb begin
		nextState = state;
		case (state)
			WAIT_COMMAND: begin
				if (o_cntLoad) begin
					case (i_cmdCode)
						CMD_STREAM: nextState = LOAD_STREAM_LO;
						CMD_QUANT:  nextState = LOAD_LUMA;
						default:    nextState = LOAD_COS;
					endcase
				end
			end
			LOAD_STREAM_LO: if (o_popLo) nextState = LOAD_STREAM_HI;
			LOAD_STREAM_HI: begin
				if (o_popHi) begin
					nextState = i_lastHalf ? WAIT_COMMAND : LOAD_STREAM_LO;
				end
			end
			LOAD_COS: if (o_cosWrite && i_lastHalf) nextState = WAIT_COMMAND;
			LOAD_LUMA: begin
				if (o_quantWrite && i_groupDone) begin
					nextState = chromaReg ? LOAD_CHROMA : WAIT_COMMAND;
				end
			end
			LOAD_CHROMA: if (o_quantWrite && i_groupDone) nextState = WAIT_COMMAND;
			default: nextState = WAIT_COMMAND;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_resetChip) begin
			state     <= WAIT_COMMAND;
			chromaReg <= 1'b0;
		end else begin
			state <= nextState;
			if (o_cntLoad) chromaReg <= i_chromaFlag;	// Kept for the whole command
		end
	end

	// Low pop leaves the word in place for the high pop
	assert property (@(posedge i_clk) disable iff (i_resetChip)
		o_popLo |=> i_fifoHasData)
		else $error("high half lost after low pop");

endmodule

`default_nettype wire

// ==== src/mdecTablePkg.sv ====
`default_nettype none

package mdecTablePkg;

	// Parameter counter, counts 16-bit halves
	typedef logic [16:0] halfCountT;

	typedef logic [15:0] halfWordT;		// One stream half-word

	// Cosine table write port
	typedef logic [4:0]  cosIndexT;
	typedef logic [25:0] cosValueT;		// Two 13-bit coefficients

	// Quantization table write port
	typedef logic [3:0]  quantAdrT;
	typedef logic [27:0] quantValueT;	// Four 7-bit factors

	// Table sizes in 32-bit words
	localparam int COS_WORDS   = 32;
	localparam int QUANT_WORDS = 16;	// Per table, luma or chroma

endpackage

`default_nettype wire

// ==== src/mdecRegPkg.sv ====
`default_nettype none

package mdecRegPkg;

	typedef logic [31:0] regWordT;		// One CPU bus word
	typedef logic [2:0]  cmdCodeT;		// Command field from bits 31..29
	typedef logic [1:0]  pixFormatT;	// 0=4bit 1=8bit 2=24bit 3=15bit

	// Known command codes
	localparam cmdCodeT CMD_STREAM = 3'd1;
	localparam cmdCodeT CMD_QUANT  = 3'd2;
	localparam cmdCodeT CMD_COSTBL = 3'd3;

	typedef enum logic [2:0] {
		WAIT_COMMAND,
		LOAD_STREAM_LO,		// Next pop takes the low half
		LOAD_STREAM_HI,		// Next pop takes the high half and retires the word
		LOAD_COS,
		LOAD_LUMA,
		LOAD_CHROMA
	} cmdStateT;

	// Status register (reg 1 read)
	localparam int STAT_FULL_BIT  = 30;
	localparam int STAT_BUSY_BIT  = 29;
	localparam int STAT_DMA0_BIT  = 28;

	// Control register (reg 1 write)
	localparam int CTRL_RESET_BIT = 31;
	localparam int CTRL_DMA0_BIT  = 30;

endpackage

`default_nettype wire
